/* binAccumulator.sv */
`default_nettype none

module binAccumulator (
    input  logic        clk,
    input  logic        combin_res,
    hisBus.acc          bus,
    output hisPkg::binT peakBin [hisPkg::pixelNum]
);
    import hisPkg::*;

    countT binCount [pixelNum][binNum];   // 16 bins for each pixel
    countT maxCount [pixelNum];           // running maximum per pixel
    countT nextCount;

    assign nextCount = binCount[bus.pixel][bus.binAddr] + 1'b1;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < pixelNum; p++) begin
                for (int b = 0; b < binNum; b++) begin
                    binCount[p][b] <= '0;
                end
                maxCount[p] <= '0;
                peakBin[p]  <= '0;
            end
        end else if (bus.passStart) begin
            for (int p = 0; p < pixelNum; p++) begin
                for (int b = 0; b < binNum; b++) begin
                    binCount[p][b] <= '0;
                end
                maxCount[p] <= '0;
                peakBin[p]  <= '0;
            end
        end else if (bus.hit && bus.inRange) begin
            binCount[bus.pixel][bus.binAddr] <= nextCount;
            // strictly greater, so the earlier bin keeps a tie
            if (nextCount > maxCount[bus.pixel]) begin
                maxCount[bus.pixel] <= nextCount;
                peakBin[bus.pixel]  <= bus.binAddr;
            end
        end
    end

endmodule

`default_nettype wire

/* binWindow.sv */
`default_nettype none

module binWindow (
    input hisPkg::sampleT lowerBound,
    hisBus.win            bus
);
    import hisPkg::*;

    sampleT offset;

    assign offset = bus.sample - lowerBound;   // wraps when below the window

    always_comb begin
        if (bus.pass == COARSE) begin
            bus.binAddr = bus.sample[sampleW-1 -: binW];   // top bits only
            bus.inRange = 1'b1;
        end else begin
            // lowerBound is at most 240, so the window never wraps past 255
            bus.binAddr = offset[binW-1:0];
            bus.inRange = (bus.sample >= lowerBound) &&
                          (offset < sampleT'(binNum));
        end
    end

endmodule

`default_nettype wire

/* hisBuilder.f */
hisPkg.sv
hisBus.sv
sampleSequencer.sv
binWindow.sv
binAccumulator.sv
peakWindowCalc.sv
hisBuilderTop.sv
tb_hisBuilder.sv

/* hisBuilderTop.sv */
`default_nettype none

module hisBuilderTop (
    input  logic           clk,
    input  logic           combin_res,
    input  logic           sampleReq,
    input  hisPkg::sampleT sample,
    input  logic           resultAck,
    output logic           sampleAck,
    output logic           resultReq,
    output hisPkg::pixelT  resultPixel,
    output hisPkg::sampleT resultPeak
);
    import hisPkg::*;

    hisBus  bus ();
    binT    peakBin [pixelNum];   // fine peaks after the second pass
    sampleT lowerBound;

    sampleSequencer uSeq (
        .clk         (clk),
        .combin_res  (combin_res),
        .sampleReq   (sampleReq),
        .sample      (sample),
        .resultAck   (resultAck),
        .sampleAck   (sampleAck),
        .resultReq   (resultReq),
        .resultPixel (resultPixel),
        .bus         (bus.seq)
    );

    binWindow uWin (
        .lowerBound (lowerBound),
        .bus        (bus.win)
    );

    binAccumulator uAcc (
        .clk        (clk),
        .combin_res (combin_res),
        .bus        (bus.acc),
        .peakBin    (peakBin)
    );

    peakWindowCalc uCalc (
        .clk         (clk),
        .combin_res  (combin_res),
        .pass        (bus.pass),
        .passStart   (bus.passStart),
        .peakBin     (peakBin),
        .pixel       (bus.pixel),
        .resultPixel (resultPixel),
        .lowerBound  (lowerBound),
        .resultPeak  (resultPeak)
    );

endmodule

`default_nettype wire

/* hisBus.sv */
`default_nettype none

interface hisBus;
    import hisPkg::*;

    logic   hit;        // one-cycle strobe, bin this sample
    pixelT  pixel;
    passT   pass;
    sampleT sample;
    binT    binAddr;
    logic   inRange;
    logic   passStart;  // one-cycle strobe, clear histograms

    modport seq (output hit, pixel, pass, sample, passStart);

    modport win (input sample, pass, pixel, output binAddr, inRange);

    modport acc (input hit, pixel, pass, sample, binAddr, inRange, passStart);

endinterface

`default_nettype wire

/* hisPkg.sv */
`default_nettype none

package hisPkg;

    localparam int sampleW  = 8;    // timestamp width
    localparam int binW     = 4;    // bin address width
    localparam int binNum   = 16;   // bins per pixel histogram
    localparam int pixelNum = 4;
    localparam int pixelW   = 2;
    localparam int dataNum  = 4;    // samples per pixel per acquisition
    localparam int dataW    = 2;
    localparam int acqNum   = 2;    // acquisitions per pass
    localparam int acqW     = 1;
    localparam int countW   = 4;    // holds 8 hits per pixel per pass
    localparam int halfWin  = 8;    // half of the fine window
    localparam int maxLower = 240;  // highest legal window start

    typedef logic [sampleW-1:0] sampleT;
    typedef logic [binW-1:0]    binT;
    typedef logic [pixelW-1:0]  pixelT;
    typedef logic [countW-1:0]  countT;

    typedef enum logic {
        COARSE = 1'b0,              // top bits of the timestamp
        FINE   = 1'b1               // 1-LSB bins inside the window
    } passT;

endpackage

`default_nettype wire

/* peakWindowCalc.sv */
`default_nettype none

module peakWindowCalc (
    input  logic           clk,
    input  logic           combin_res,
    input  hisPkg::passT   pass,
    input  logic           passStart,
    input  hisPkg::binT    peakBin [hisPkg::pixelNum],
    input  hisPkg::pixelT  pixel,
    input  hisPkg::pixelT  resultPixel,
    output hisPkg::sampleT lowerBound,
    output hisPkg::sampleT resultPeak
);
    import hisPkg::*;

    sampleT lowerReg [pixelNum];   // fine window start per pixel

    // coarse bin start minus half a window, floored at 0
    function automatic sampleT clampLower(input binT bin);
        logic [sampleW:0] centre;
        centre = {1'b0, bin, {(sampleW - binW){1'b0}}};
        if (centre <= (sampleW + 1)'(halfWin)) begin
            return '0;
        end
        return sampleT'(centre - (sampleW + 1)'(halfWin));
    endfunction

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < pixelNum; p++) begin
                lowerReg[p] <= '0;
            end
        end else if (passStart && pass == COARSE) begin
            for (int p = 0; p < pixelNum; p++) begin
                lowerReg[p] <= clampLower(peakBin[p]);   // coarse peaks still held
            end
        end
    end

    assign lowerBound = lowerReg[pixel];
    assign resultPeak = lowerReg[resultPixel] + sampleT'(peakBin[resultPixel]);

endmodule

`default_nettype wire

/* runSim.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_hisBuilder -f hisBuilder.f \
    && ./obj_dir/Vtb_hisBuilder | tee /dev/stderr | grep -q "^RESULT: PASS$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sampleSequencer.sv */
`default_nettype none

module sampleSequencer (
    input  logic           clk,
    input  logic           combin_res,
    input  logic           sampleReq,
    input  hisPkg::sampleT sample,
    input  logic           resultAck,
    output logic           sampleAck,
    output logic           resultReq,
    output hisPkg::pixelT  resultPixel,
    hisBus.seq             bus
);
    import hisPkg::*;

    typedef enum logic [1:0] {
        sIntake,    // waiting for a sample request
        sWaitLow,   // acked, waiting for the request to drop
        sReadout    // handing out the four peaks
    } seqStateT;

    seqStateT         state;
    logic [dataW-1:0] inCnt;
    pixelT            pixCnt;
    logic [acqW-1:0]  acqCnt;
    passT             pass;
    sampleT           sampleReg;
    logic             hit;
    logic             passStart;
    logic             goReadout;   // accepted sample closes a fine pass
    logic             lastSample;

    assign lastSample = (inCnt == dataW'(dataNum - 1)) &&
                        (pixCnt == pixelT'(pixelNum - 1)) &&
                        (acqCnt == acqW'(acqNum - 1));

    assign bus.hit       = hit;
    assign bus.passStart = passStart;
    assign bus.pixel     = pixCnt;    // counters hold until ack falls
    assign bus.pass      = pass;
    assign bus.sample    = sampleReg;

    always_ff @(posedge clk) begin
        if (state == sIntake && sampleReq) begin
            sampleReg <= sample;   // captured on the ack edge
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state       <= sIntake;
            sampleAck   <= 1'b0;
            resultReq   <= 1'b0;
            resultPixel <= '0;
            inCnt       <= '0;
            pixCnt      <= '0;
            acqCnt      <= '0;
            pass        <= COARSE;
            hit         <= 1'b0;
            passStart   <= 1'b0;
            goReadout   <= 1'b0;
        end else begin
            hit       <= 1'b0;
            passStart <= 1'b0;
            if (passStart) begin
                pass <= (pass == COARSE) ? FINE : COARSE;
            end
            // last coarse update lands first, then clear
            if (hit && lastSample && pass == COARSE) begin
                passStart <= 1'b1;
            end
            case (state)
                sIntake: begin
                    if (sampleReq) begin
                        sampleAck <= 1'b1;
                        hit       <= 1'b1;
                        goReadout <= lastSample && (pass == FINE);
                        state     <= sWaitLow;
                    end
                end
                sWaitLow: begin
                    if (!sampleReq) begin
                        sampleAck <= 1'b0;
                        if (inCnt == dataW'(dataNum - 1)) begin
                            inCnt <= '0;
                            if (pixCnt == pixelT'(pixelNum - 1)) begin
                                pixCnt <= '0;
                                if (acqCnt == acqW'(acqNum - 1)) begin
                                    acqCnt <= '0;
                                end else begin
                                    acqCnt <= acqCnt + 1'b1;
                                end
                            end else begin
                                pixCnt <= pixCnt + 1'b1;
                            end
                        end else begin
                            inCnt <= inCnt + 1'b1;
                        end
                        if (goReadout) begin
                            resultReq <= 1'b1;   // pixel 0 first
                            state     <= sReadout;
                        end else begin
                            state <= sIntake;
                        end
                    end
                end
                sReadout: begin
                    if (resultReq && resultAck) begin
                        resultReq <= 1'b0;
                        if (resultPixel == pixelT'(pixelNum - 1)) begin
                            resultPixel <= '0;
                            passStart   <= 1'b1;   // back to coarse
                            state       <= sIntake;
                        end
                    end else if (!resultReq && !resultAck) begin
                        resultPixel <= resultPixel + 1'b1;
                        resultReq   <= 1'b1;
                    end
                end
                default: state <= sIntake;
            endcase
        end
    end

endmodule

`default_nettype wire

/* tb_hisBuilder.sv */
`default_nettype none

module tb_hisBuilder;
    import hisPkg::*;

    localparam int passLen    = acqNum * pixelNum * dataNum;   // 32 samples per pass
    localparam int frameLen   = 2 * passLen;
    localparam int rowNum     = 4;
    localparam int frameTot   = rowNum + 3;   // rows, random, partial, after reset
    localparam int cycleLimit = frameTot * (frameLen * 8 + pixelNum * 10) * 2;

    // offsets per sample of one pixel, acquisition major
    localparam int spread [3][8] = '{
        '{0, 1, 0, -1, 0, 2, 0, 1},          // tight cluster
        '{0, 100, 0, -90, 0, 0, 60, 1},      // distant outliers
        '{2, 4, 4, 2, 40, -40, 60, -60}      // two fine bins tie at two hits
    };
    localparam int rowCoarse [rowNum][pixelNum] = '{
        '{100, 130, 70, 200}, '{3, 244, 10, 250}, '{120, 128, 150, 100}, '{128, 64, 176, 100}
    };
    localparam int rowFine [rowNum][pixelNum] = '{
        '{100, 131, 60, 190}, '{5, 245, 1, 236}, '{110, 125, 140, 103}, '{124, 60, 170, 96}
    };
    localparam int rowPat [rowNum][pixelNum] = '{
        '{0, 0, 0, 0}, '{0, 0, 0, 0}, '{1, 1, 1, 1}, '{2, 2, 2, 2}
    };
    localparam int rowPeak [rowNum][pixelNum] = '{
        '{100, 131, 60, 190}, '{5, 245, 1, 236}, '{110, 125, 140, 103}, '{128, 64, 174, 100}
    };

    logic   clk;
    logic   combin_res;
    logic   sampleReq;
    sampleT sample;
    logic   resultAck;
    logic   sampleAck;
    logic   resultReq;
    pixelT  resultPixel;
    sampleT resultPeak;

    sampleT frameBuf [frameLen];
    sampleT expPeaks [pixelNum];
    sampleT sampleQ [$];
    sampleT expectQ [$];
    int     seed;
    int     cycleCnt;
    int     acceptedCnt;
    int     resultsDone;
    int     checkCnt;
    int     valErr;
    int     hsErr;

    hisBuilderTop UUT (
        .clk         (clk),
        .combin_res  (combin_res),
        .sampleReq   (sampleReq),
        .sample      (sample),
        .resultAck   (resultAck),
        .sampleAck   (sampleAck),
        .resultReq   (resultReq),
        .resultPixel (resultPixel),
        .resultPeak  (resultPeak)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt > cycleLimit) begin
            $display("timeout after %0d cycles, the DUT stopped responding", cycleCnt);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic checkValue(input string name, input int expected, input int actual);
        checkCnt++;
        assert (expected == actual) else begin
            valErr++;
            $display("error %0t %s expected %0d got %0d", $time, name, expected, actual);
        end
    endtask

    // one frame in intake order: pass, acquisition, pixel, sample
    task automatic buildRow(input int r);
        int k;
        k = 0;
        for (int ps = 0; ps < 2; ps++)
            for (int a = 0; a < acqNum; a++)
                for (int p = 0; p < pixelNum; p++)
                    for (int d = 0; d < dataNum; d++) begin
                        frameBuf[k] = sampleT'((ps == 0 ? rowCoarse[r][p] : rowFine[r][p]) +
                                               spread[rowPat[r][p]][a * dataNum + d]);
                        k++;
                    end
    endtask

    task automatic buildRandom();
        int centre [pixelNum];
        for (int p = 0; p < pixelNum; p++) centre[p] = $random(seed) & 255;
        for (int k = 0; k < frameLen; k++) begin
            frameBuf[k] = sampleT'(centre[(k / dataNum) % pixelNum] + ($random(seed) & 7) - 3);
            if (($random(seed) & 15) == 0) frameBuf[k] = sampleT'($random(seed));   // stray hit
        end
    endtask

    // reference peaks straight from the binning, window and tie rules
    task automatic computePeaks();
        int cnt [pixelNum][binNum];
        int maxC [pixelNum];
        int peak [pixelNum];
        int lower [pixelNum];
        int s;
        int p;
        int b;
        for (int ps = 0; ps < 2; ps++) begin
            for (int q = 0; q < pixelNum; q++) begin
                maxC[q] = 0;
                peak[q] = 0;
                for (int i = 0; i < binNum; i++) cnt[q][i] = 0;
            end
            for (int j = 0; j < passLen; j++) begin
                s = int'(frameBuf[ps * passLen + j]);
                p = (j / dataNum) % pixelNum;
                b = (ps == 0) ? s / binNum : s - lower[p];
                if (b >= 0 && b < binNum) begin
                    cnt[p][b]++;
                    if (cnt[p][b] > maxC[p]) begin   // earlier bin keeps a tie
                        maxC[p] = cnt[p][b];
                        peak[p] = b;
                    end
                end
            end
            if (ps == 0) begin
                for (int q = 0; q < pixelNum; q++) begin
                    lower[q] = peak[q] * binNum - halfWin;
                    if (lower[q] < 0) lower[q] = 0;
                    if (lower[q] > maxLower) lower[q] = maxLower;
                end
            end
        end
        for (int q = 0; q < pixelNum; q++) expPeaks[q] = sampleT'(lower[q] + peak[q]);
    endtask

    task automatic queueFrame(input int n);
        for (int k = 0; k < n; k++) sampleQ.push_back(frameBuf[k]);
    endtask

    task automatic sendSamples();
        forever begin
            @(posedge clk);
            if (sampleQ.size() > 0) begin
                sample    <= sampleQ.pop_front();
                sampleReq <= 1'b1;   // held through any readout
                do @(posedge clk); while (!sampleAck);
                assert (acceptedCnt / frameLen <= resultsDone / pixelNum) else begin
                    hsErr++;
                    $display("sample %0d was accepted before the previous frame was read out",
                             acceptedCnt);
                end
                acceptedCnt++;
                sampleReq <= 1'b0;
                do @(posedge clk); while (sampleAck);
            end
        end
    endtask

    task automatic collectResults();
        int delay;
        forever begin
            @(posedge clk);
            if (resultReq) begin
                checkValue("resultPixel", resultsDone % pixelNum, int'(resultPixel));
                if (expectQ.size() > 0) begin
                    checkValue("resultPeak", int'(expectQ.pop_front()), int'(resultPeak));
                end else begin
                    hsErr++;
                    $display("a result was offered when none was expected");
                end
                assert (!sampleAck) else begin
                    hsErr++;
                    $display("a sample was acknowledged during result readout");
                end
                delay = $random(seed) & 7;   // back-pressure on the result side
                repeat (delay) @(posedge clk);
                resultAck <= 1'b1;
                do @(posedge clk); while (resultReq);
                resultAck <= 1'b0;
                resultsDone++;
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        combin_res  = 1'b0;
        sampleReq   = 1'b0;
        sample      = '0;
        resultAck   = 1'b0;
        seed        = 58;
        cycleCnt    = 0;
        acceptedCnt = 0;
        resultsDone = 0;
        checkCnt    = 0;
        valErr      = 0;
        hsErr       = 0;
        fork
            sendSamples();
            collectResults();
        join_none
        repeat (5) @(posedge clk);
        combin_res <= 1'b1;
        for (int r = 0; r < rowNum; r++) begin
            buildRow(r);
            queueFrame(frameLen);
            for (int p = 0; p < pixelNum; p++) expectQ.push_back(sampleT'(rowPeak[r][p]));
        end
        buildRandom();
        computePeaks();
        queueFrame(frameLen);
        for (int p = 0; p < pixelNum; p++) expectQ.push_back(expPeaks[p]);
        while (resultsDone < (rowNum + 1) * pixelNum) @(posedge clk);

        buildRow(2);
        queueFrame(20);   // stop partway through the coarse pass
        while (sampleQ.size() != 0) @(posedge clk);
        while (!sampleAck) @(posedge clk);
        combin_res <= 1'b0;   // reset while the last sample is still acked
        @(posedge clk);
        checkValue("sampleAck", 0, int'(sampleAck));
        checkValue("resultReq", 0, int'(resultReq));
        repeat (4) @(posedge clk);
        combin_res <= 1'b1;
        acceptedCnt = 0;
        resultsDone = 0;
        buildRow(0);
        queueFrame(frameLen);
        for (int p = 0; p < pixelNum; p++) expectQ.push_back(sampleT'(rowPeak[0][p]));
        while (resultsDone < pixelNum) @(posedge clk);

        $display("checks %0d, value errors %0d, handshake errors %0d", checkCnt, valErr, hsErr);
        if (valErr + hsErr == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
